// ==== logic/csi_rx_pkg.sv ====
// csi-2 receiver shared definitions
// widths, data type codes, buffer sizing and the short packet event

package csi_rx_pkg;

   // ------------------------------
   // basic types
   // ------------------------------
   typedef logic [15:0] lane_data_t;   // aligned word, lane 1 in high byte
   typedef logic [5:0]  data_type_t;   // csi-2 data identifier type field

   localparam logic [7:0] SYNC_BYTE = 8'hB8;

   // short packet types
   localparam data_type_t DT_FS = 6'h00;   // frame start
   localparam data_type_t DT_FE = 6'h01;   // frame end
   localparam data_type_t DT_LS = 6'h02;   // line start
   localparam data_type_t DT_LE = 6'h03;   // line end

   // long packet type ranges
   localparam data_type_t DT_NONIMG_LO = 6'h10;
   localparam data_type_t DT_NONIMG_HI = 6'h12;
   localparam data_type_t DT_RAW_LO    = 6'h28;   // raw6
   localparam data_type_t DT_RAW_HI    = 6'h2D;   // raw14

   // event stream entry for short packets
   typedef struct packed {
      data_type_t  dtype;   // short packet type
      logic [15:0] data;    // frame or line number field
   } short_event_t;

   // ------------------------------
   // sizing
   // ------------------------------
   localparam int MAX_PAYLOAD_BYTES = 8192;
   localparam logic [15:0] MAX_COUNT_BYTES = 16'(MAX_PAYLOAD_BYTES + 2);  // payload plus footer
   localparam int BUF_DEPTH = 16;                   // power of two, pointers wrap
   localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
   localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

   // types the receiver accepts, everything else is dropped
   function automatic logic is_allowed_type(input data_type_t dt);
      return dt inside {[DT_FS:DT_LE], [DT_NONIMG_LO:DT_NONIMG_HI],
                        [DT_RAW_LO:DT_RAW_HI]};
   endfunction

endpackage

// ==== logic/csi_rx_hdr_ecc.sv ====
// csi-2 packet header ecc generator
// hamming parity over the 24 header bits (data id and word count)
// purely combinational, top two ecc bits always zero

`timescale 1ns/10ps

module csi_rx_hdr_ecc (
   input  logic [23:0] data,   // {wc_hi, wc_lo, data id}
   output logic [7:0]  ecc     // expected ecc byte
);

   logic [5:0] p;

   // parity table from the csi-2 spec
   // each parity bit covers a fixed subset of header bits
   always_comb begin
      p[0] = ^{data[0], data[1], data[2], data[4], data[5], data[7],
               data[10], data[11], data[13], data[16],
               data[20], data[21], data[22], data[23]};

      p[1] = ^{data[0], data[1], data[3], data[4], data[6], data[8],
               data[10], data[12], data[14], data[17],
               data[20], data[21], data[22], data[23]};

      p[2] = ^{data[0], data[2], data[3], data[5], data[6], data[9],
               data[11], data[12], data[15], data[18],
               data[20], data[21], data[22]};

      p[3] = ^{data[1], data[2], data[3], data[7], data[8], data[9],
               data[13], data[14], data[15], data[19],
               data[20], data[21], data[23]};

      p[4] = ^{data[4], data[5], data[6], data[7], data[8], data[9],
               data[16], data[17], data[18], data[19],
               data[20], data[22], data[23]};

      p[5] = ^{data[10], data[11], data[12], data[13], data[14], data[15],
               data[16], data[17], data[18], data[19],
               data[21], data[22], data[23]};
   end

   assign ecc = {2'b00, p};   // bits 7:6 reserved

endmodule

// ==== logic/csi_rx_word_aligner.sv ====
// two lane word aligner
// hunts for the sync byte on both lanes, removes up to one cycle of
// lane skew and emits 16 bit words, lane 0 in the low byte

`timescale 1ns/10ps

module csi_rx_word_aligner
   import csi_rx_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  logic [7:0] lane0_byte,
   input  logic [7:0] lane1_byte,
   input  logic       lane_valid,    // high speed burst active
   input  logic       sync_wait,     // handler idle, wants a sync word
   input  logic       packet_done,   // stop and wait for burst end
   output lane_data_t word,
   output logic       word_valid
);

   typedef enum logic [1:0] {HUNT, STREAM, DRAIN} align_state_t;

   align_state_t state;
   logic [7:0] l0_q, l0_qq, l1_q, l1_qq;   // two stage byte delay lines
   logic       lv_q, lv_qq;
   logic       delay0, delay1;               // lane runs one cycle early
   logic       both_now, l0_early, l1_early, found;
   logic       delay0_n, delay1_n;

   // ------------------------------
   // sync detect on delayed bytes
   // ------------------------------
   always_comb begin
      both_now = lv_q && (l0_q == SYNC_BYTE) && (l1_q == SYNC_BYTE);
      l0_early = lv_q && lv_qq && (l0_qq == SYNC_BYTE) && (l1_q == SYNC_BYTE);
      l1_early = lv_q && lv_qq && (l1_qq == SYNC_BYTE) && (l0_q == SYNC_BYTE);
      found    = (state == HUNT) && sync_wait && (both_now || l0_early || l1_early);
      delay0_n = delay0;                     // keep skew while streaming
      delay1_n = delay1;
      if (state == HUNT) begin
         delay0_n = !both_now && l0_early;   // aligned case wins
         delay1_n = !both_now && !l0_early && l1_early;
      end
   end

   always_ff @(posedge clock) begin          // data path, no reset
      l0_q  <= lane0_byte;
      l1_q  <= lane1_byte;
      l0_qq <= l0_q;
      l1_qq <= l1_q;
      word  <= {delay1_n ? l1_qq : l1_q, delay0_n ? l0_qq : l0_q};
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state      <= HUNT;
         lv_q       <= 1'b0;
         lv_qq      <= 1'b0;
         delay0     <= 1'b0;
         delay1     <= 1'b0;
         word_valid <= 1'b0;
      end else begin
         lv_q       <= lane_valid;
         lv_qq      <= lv_q;
         word_valid <= 1'b0;
         delay0     <= delay0_n;
         delay1     <= delay1_n;
         case (state)
            HUNT: if (found) begin
               state      <= STREAM;
               word_valid <= 1'b1;           // this word is B8B8
            end
            STREAM: if (packet_done) begin
               state <= DRAIN;               // rest of burst is ignored
            end else if (!lv_q) begin
               state <= HUNT;                // burst ended mid packet
            end else begin
               word_valid <= 1'b1;
            end
            DRAIN: if (!lane_valid) state <= HUNT;   // next burst is fresh
            default: state <= HUNT;
         endcase
      end
   end

endmodule

// ==== logic/csi_rx_byte_counter.sv ====
// long packet byte counter
// tracks remaining payload plus footer bytes, two bytes per word

`timescale 1ns/10ps

module csi_rx_byte_counter
   import csi_rx_pkg::*;
(
   input  logic        clock,
   input  logic        reset,
   input  logic        count_load,     // header accepted
   input  logic [15:0] count_length,   // word count plus footer
   input  logic        count_step,     // one word consumed
   output logic        count_last      // current word is the final one
);

   logic [15:0] remaining;   // bytes left including the current word
   logic [15:0] capped;

   // oversized word counts are clamped like the payload limit
   assign capped = (count_length > MAX_COUNT_BYTES) ? MAX_COUNT_BYTES : count_length;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         remaining <= '0;
      end else if (count_load) begin
         if (!count_step)
            remaining <= capped;
         else
            remaining <= (capped > 16'd2) ? capped - 16'd2 : '0;  // first word with load
      end else if (count_step) begin
         remaining <= (remaining > 16'd2) ? remaining - 16'd2 : '0;
      end
   end

   assign count_last = (remaining <= 16'd2);

endmodule

// ==== logic/csi_rx_packet_handler.sv ====
// csi-2 packet handler
// assembles and checks the packet header, routes long packet payload
// and short packet events, tracks frame and line state
// asks the aligner for a new sync word when idle

`timescale 1ns/10ps

module csi_rx_packet_handler
   import csi_rx_pkg::*;
(
   input  logic         clock,
   input  logic         reset,
   input  lane_data_t   word,           // from aligner
   input  logic         word_valid,
   output logic         sync_wait,      // idle, hunting for sync
   output logic         packet_done,    // one cycle, aligner drains
   output logic         count_load,
   output logic [15:0]  count_length,
   output logic         count_step,
   input  logic         count_last,
   output logic         pay_push,
   output lane_data_t   pay_word,
   output logic         evt_push,
   output short_event_t evt_value,
   output logic         in_frame,
   output logic         in_line,
   output logic         ecc_error
);

   typedef enum logic [2:0] {
      START, SYNC0, SYNC1, HDR_WAIT, LONG_READ, DONE, STOP
   } state_t;

   state_t      state;
   logic [31:0] hdr;            // {ecc, wc_hi, wc_lo, data id}
   logic [23:0] hdr_bits;
   logic [7:0]  expected_ecc;
   data_type_t  hdr_type;
   logic [15:0] hdr_data;       // word count or short packet data
   logic        checking;       // header complete this cycle
   logic        ecc_ok, hdr_ok, long_ok;

   // ------------------------------
   // header decode and checks
   // ------------------------------
   always_comb begin
      checking     = (state == HDR_WAIT);
      hdr_bits     = hdr[23:0];
      hdr_type     = hdr[5:0];
      hdr_data     = hdr[23:8];
      ecc_ok       = (hdr[31:24] == expected_ecc);
      hdr_ok       = ecc_ok && is_allowed_type(hdr_type) && (hdr[7:6] == 2'b00);  // vc 0 only
      long_ok      = hdr_ok && (hdr_type > 6'h0F);
      count_length = hdr_data + 16'd2;                    // footer included
      count_load   = checking && long_ok;
      count_step   = word_valid && (count_load || (state == LONG_READ));
   end

   csi_rx_hdr_ecc i_ecc (
      .data (hdr_bits),
      .ecc  (expected_ecc)
   );

   assign sync_wait   = (state == START);
   assign packet_done = (state == DONE);

   // header shift and payload capture, no reset on data
   always_ff @(posedge clock) begin
      if (word_valid) hdr <= {word, hdr[31:16]};   // second word lands on top
      pay_word        <= word;
      evt_value.dtype <= hdr_type;
      evt_value.data  <= hdr_data;
   end

   // ------------------------------
   // packet FSM
   // ------------------------------
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state <= START;
      end else begin
         case (state)
            START:    if (word_valid && word == {SYNC_BYTE, SYNC_BYTE}) state <= SYNC0;
            SYNC0:    if (word_valid) state <= SYNC1;   // di and wc low
            SYNC1:    if (word_valid) state <= HDR_WAIT;  // wc high and ecc
            HDR_WAIT: begin
               if (!long_ok)
                  state <= DONE;                        // short or rejected
               else if (word_valid && count_length <= 16'd2)
                  state <= DONE;                        // empty payload, footer only
               else
                  state <= LONG_READ;
            end
            LONG_READ: if (word_valid && count_last) state <= DONE;   // footer word
            DONE:     state <= STOP;
            STOP:     state <= START;
            default:  state <= START;
         endcase
      end
   end

   // ------------------------------
   // output pushes and status
   // ------------------------------
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         pay_push  <= 1'b0;
         evt_push  <= 1'b0;
         ecc_error <= 1'b0;
         in_frame  <= 1'b0;
         in_line   <= 1'b0;
      end else begin
         // footer word is the one with count_last, never pushed
         pay_push  <= word_valid &&
                      ((count_load && count_length > 16'd2) ||
                       (state == LONG_READ && !count_last));
         evt_push  <= checking && hdr_ok && !long_ok;
         ecc_error <= checking && !ecc_ok;     // single cycle pulse
         if (checking && hdr_ok && hdr_type == DT_FS)
            in_frame <= 1'b1;
         else if (checking && hdr_ok && hdr_type == DT_FE)
            in_frame <= 1'b0;
         if (count_load)
            in_line <= 1'b1;
         else if (state == DONE)
            in_line <= 1'b0;
      end
   end

endmodule

// ==== logic/csi_rx_stream_buffer.sv ====
// stream output buffer
// small circular FIFO with valid/ready output, the sensor side cannot
// stall so a push into a full buffer is lost and flagged

`timescale 1ns/10ps

module csi_rx_stream_buffer
   import csi_rx_pkg::*;
#(
   parameter type payload_t = lane_data_t
) (
   input  logic     clock,
   input  logic     reset,
   input  logic     push,
   input  payload_t push_data,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready,
   output logic     overflow     // sticky until reset
);

   payload_t             mem [BUF_DEPTH];
   logic [BUF_PTR_W-1:0] wr_ptr, rd_ptr;
   logic [BUF_CNT_W-1:0] count;        // occupancy
   logic                 full, wr_en, pop;

   always_comb begin
      full  = (count == BUF_CNT_W'(BUF_DEPTH));
      wr_en = push && !full;            // drop when full
      pop   = out_valid && out_ready;
   end

   // ------------------------------
   // storage
   // ------------------------------
   always_ff @(posedge clock) begin
      if (wr_en) mem[wr_ptr] <= push_data;
   end

   assign out_data  = mem[rd_ptr];     // head entry, stable until popped
   assign out_valid = (count != '0);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (pop)   rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (push && full) overflow <= 1'b1;
      end
   end

endmodule

// ==== logic/csi_rx_top.sv ====
// two lane csi-2 receiver packet layer
// aligner, packet handler, byte counter and the payload and event
// output buffers

`timescale 1ns/10ps

module csi_rx_top
   import csi_rx_pkg::*;
(
   input  logic        clock,
   input  logic        reset,
   input  logic [7:0]  lane0_byte,
   input  logic [7:0]  lane1_byte,
   input  logic        lane_valid,
   // payload stream
   output lane_data_t  payload_data,
   output logic        payload_valid,
   input  logic        payload_ready,
   // short packet event stream
   output data_type_t  event_type,
   output logic [15:0] event_data,
   output logic        event_valid,
   input  logic        event_ready,
   // status
   output logic        in_frame,
   output logic        in_line,
   output logic        ecc_error,
   output logic        payload_overflow,
   output logic        event_overflow
);

   lane_data_t   word, pay_word;
   logic         word_valid, sync_wait, packet_done;
   logic         count_load, count_step, count_last;
   logic [15:0]  count_length;
   logic         pay_push, evt_push;
   short_event_t evt_value, evt_out;

   // ------------------------------
   // front end
   // ------------------------------
   csi_rx_word_aligner i_aligner (
      .clock, .reset, .lane0_byte, .lane1_byte, .lane_valid,
      .sync_wait, .packet_done, .word, .word_valid
   );

   csi_rx_packet_handler i_handler (
      .clock, .reset, .word, .word_valid, .sync_wait, .packet_done,
      .count_load, .count_length, .count_step, .count_last,
      .pay_push, .pay_word, .evt_push, .evt_value,
      .in_frame, .in_line, .ecc_error
   );

   csi_rx_byte_counter i_counter (
      .clock, .reset, .count_load, .count_length, .count_step, .count_last
   );

   // ------------------------------
   // output buffers
   // ------------------------------
   csi_rx_stream_buffer #(.payload_t(lane_data_t)) i_pay_buf (
      .clock, .reset, .push(pay_push), .push_data(pay_word),
      .out_data(payload_data), .out_valid(payload_valid),
      .out_ready(payload_ready), .overflow(payload_overflow)
   );

   csi_rx_stream_buffer #(.payload_t(short_event_t)) i_evt_buf (
      .clock, .reset, .push(evt_push), .push_data(evt_value),
      .out_data(evt_out), .out_valid(event_valid),
      .out_ready(event_ready), .overflow(event_overflow)
   );

   assign event_type = evt_out.dtype;   // split the event fields
   assign event_data = evt_out.data;

endmodule

// ==== testbench/csi_rx_props.sv ====
// protocol assertions for the packet handler and the stream buffers
// bound into every instance of both modules, unused inputs tied off

`timescale 1ns/10ps

module csi_rx_props (
   input logic        clock,
   input logic        reset,
   input logic        hdr_check,    // handler header check cycle
   input logic        read_state,   // handler in the long packet read
   input logic        pay_push,
   input logic        ecc_error,
   input logic        out_valid,
   input logic        out_ready,
   input logic [31:0] out_data,
   input logic        overflow
);

   // ------------------------------
   // handler
   // ------------------------------
   a_ecc_after_check: assert property (@(posedge clock) disable iff (reset)
      ecc_error |-> $past(hdr_check) && !read_state)
      else $error("ecc_error without a header check or a read started");

   a_push_in_read: assert property (@(posedge clock) disable iff (reset)
      pay_push |-> read_state)
      else $error("payload push outside the long packet read");

   // ------------------------------
   // buffers
   // ------------------------------
   a_hold_data: assert property (@(posedge clock) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("buffer output changed while stalled");

   a_sticky_overflow: assert property (@(posedge clock) disable iff (reset)
      overflow |=> overflow)
      else $error("overflow flag fell without reset");

endmodule

bind csi_rx_packet_handler csi_rx_props i_props (
   .clock, .reset, .hdr_check(checking),
   .read_state(state == LONG_READ),
   .pay_push, .ecc_error,
   .out_valid(1'b0), .out_ready(1'b1), .out_data(32'd0), .overflow(1'b0)
);

bind csi_rx_stream_buffer csi_rx_props i_props (
   .clock, .reset, .hdr_check(1'b0), .read_state(1'b1),
   .pay_push(1'b0), .ecc_error(1'b0),
   .out_valid, .out_ready, .out_data(32'(out_data)), .overflow
);

// ==== testbench/csi_rx_tb.sv ====
// csi-2 receiver testbench
// random frames of short and long packets with lane skew and idle gaps,
// scoreboard on the payload and event streams, overflow phase at the end

`timescale 1ns/10ps

module csi_rx_tb;
   import csi_rx_pkg::*;

   localparam time PERIOD = 40ns;

   typedef logic [7:0] byte_q_t[$];

   logic        clock, reset;
   logic [7:0]  lane0_byte, lane1_byte;
   logic        lane_valid;
   logic        payload_ready = 1'b0;
   logic        event_ready   = 1'b0;
   lane_data_t  payload_data;
   data_type_t  event_type;
   logic [15:0] event_data;
   logic        payload_valid, event_valid, in_frame, in_line, ecc_error;
   logic        payload_overflow, event_overflow;

   lane_data_t  exp_pay[$];        // expected payload words in order
   logic [21:0] exp_evt[$];        // expected {type, data}
   data_type_t  sent_type;         // short packet type now on the lanes
   int          byte_count, ecc_seen, ecc_expected;
   bit          hold_pay, passed, fail_shown;

   csi_rx_top i_dut (.*);

   initial begin
      clock = 1'b0;
      forever #(PERIOD / 2) clock = ~clock;
   end

   // ------------------------------
   // reporting
   // ------------------------------
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Testbench failed");
      fail_shown = 1'b1;
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected)
         stop_run($sformatf("Fail: time %0t signal %s actual %h expected %h",
                            $time, name, actual, expected));
   endtask

   // ------------------------------
   // packet building
   // ------------------------------
   // hamming parity masks over {wc_hi, wc_lo, data id}
   function automatic logic [31:0] make_header(input data_type_t dt, input logic [15:0] data);
      logic [23:0] masks [6];
      logic [23:0] bits;
      logic [7:0]  e;
      masks = '{24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00};
      bits  = {data, 2'b00, dt};   // virtual channel 0
      e     = 8'h00;
      for (int i = 0; i < 6; i++) e[i] = ^(bits & masks[i]);
      return {e, bits};
   endfunction

   function automatic logic [7:0] lane_byte(input byte_q_t q, input int idx);
      return (idx >= 0 && idx < q.size()) ? q[idx] : 8'h55;   // idle filler
   endfunction

   // one burst: sync, packet bytes split over the lanes, short trailer, idle gap
   task automatic send_burst(input byte_q_t pkt);
      byte_q_t l0, l1;
      int      skew0, skew1, n;
      l0.push_back(SYNC_BYTE);
      l1.push_back(SYNC_BYTE);
      foreach (pkt[i]) begin
         if (i % 2 == 0) l0.push_back(pkt[i]);
         else            l1.push_back(pkt[i]);
      end
      skew0 = $urandom_range(0, 1);              // late lane lags one cycle
      skew1 = skew0 ? 0 : $urandom_range(0, 1);
      n     = l0.size() + 3;                     // skew cycle plus trailer
      byte_count += 2 * n;
      for (int c = 0; c < n; c++) begin
         @(negedge clock);
         lane_valid = 1'b1;
         lane0_byte = lane_byte(l0, c - skew0);
         lane1_byte = lane_byte(l1, c - skew1);
      end
      @(negedge clock);
      lane_valid = 1'b0;
      lane0_byte = 8'h00;
      lane1_byte = 8'h00;
      repeat ($urandom_range(4, 10)) @(negedge clock);
   endtask

   task automatic send_short(input data_type_t dt, input logic [15:0] data);
      byte_q_t     pkt;
      logic [31:0] hdr;
      hdr = make_header(dt, data);
      for (int i = 0; i < 4; i++) pkt.push_back(hdr[8*i +: 8]);
      exp_evt.push_back({dt, data});
      sent_type = dt;
      send_burst(pkt);
   endtask

   // raw8 line, corrupt flips one header bit so the whole packet is lost
   task automatic send_line(input int len, input bit corrupt);
      byte_q_t     pkt;
      logic [31:0] hdr;
      int          flip;
      hdr = make_header(6'h2A, 16'(len));
      if (corrupt) begin
         flip = $urandom_range(0, 31);
         hdr[flip] ^= 1'b1;
         ecc_expected++;
      end
      for (int i = 0; i < 4; i++) pkt.push_back(hdr[8*i +: 8]);
      for (int i = 0; i < len; i++) pkt.push_back(8'($urandom));
      for (int i = 0; i < len && !corrupt; i += 2) begin
         if (!hold_pay || i < 2 * BUF_DEPTH)           // stalled buffer keeps first words
            exp_pay.push_back({pkt[i + 5], pkt[i + 4]});
      end
      pkt.push_back(8'($urandom));                      // footer, never delivered
      pkt.push_back(8'($urandom));
      send_burst(pkt);
   endtask

   // ------------------------------
   // consumers and status monitor
   // ------------------------------
   always @(negedge clock) begin
      payload_ready = hold_pay ? 1'b0 : ($urandom_range(0, 3) != 0);   // for the next edge
      event_ready   = ($urandom_range(0, 3) != 0);
      if (!reset) begin
         if (payload_valid && payload_ready) begin      // transfer at next edge
            if (exp_pay.size() == 0) stop_run("payload word arrived with none expected");
            else check("payload_data", payload_data, exp_pay.pop_front());
         end
         if (event_valid && event_ready) begin
            if (exp_evt.size() == 0) stop_run("event arrived with none expected");
            else check("event_type_data", {event_type, event_data}, exp_evt.pop_front());
         end
         if (ecc_error) ecc_seen++;
         if (i_dut.pay_push) begin
            check("in_line", in_line, 1'b1);
            check("in_frame", in_frame, 1'b1);
         end
         if (i_dut.evt_push) begin
            check("in_line", in_line, 1'b0);
            check("in_frame", in_frame, sent_type != DT_FE);   // open from fs until fe
         end
      end
   end

   // watchdog, budget grows with every generated byte
   initial begin
      int cycles;
      cycles = 0;
      forever begin
         @(posedge clock);
         cycles++;
         if (cycles > 40 * byte_count + 2000)
            stop_run("timeout, the output streams did not drain in time");
      end
   end

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      int lines;
      void'($urandom(32'hb397));
      reset      = 1'b1;
      lane_valid = 1'b0;
      lane0_byte = 8'h00;
      lane1_byte = 8'h00;
      repeat (4) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      check("status_after_reset", {payload_valid, event_valid, in_frame, in_line,
            ecc_error, payload_overflow, event_overflow}, 7'b0);
      for (int f = 0; f < 5; f++) begin
         send_short(DT_FS, 16'(f + 1));
         lines = $urandom_range(3, 6);
         for (int l = 1; l <= lines; l++) begin
            send_short(DT_LS, 16'(l));
            send_line(2 * $urandom_range(1, 20), (f == 1 && l == 2) || $urandom_range(0, 5) == 0);
            send_short(DT_LE, 16'(l));
         end
         send_short(DT_FE, 16'(f + 1));
      end
      // stalled payload stream for one long line
      send_short(DT_FS, 16'd9);
      while (exp_pay.size() != 0) @(negedge clock);
      hold_pay = 1'b1;
      send_line(40, 1'b0);
      check("payload_overflow", payload_overflow, 1'b1);
      hold_pay = 1'b0;
      send_short(DT_FE, 16'd9);
      while (exp_pay.size() != 0 || exp_evt.size() != 0) @(negedge clock);
      repeat (4) @(negedge clock);
      check("payload_overflow", payload_overflow, 1'b1);
      check("event_overflow", event_overflow, 1'b0);
      check("ecc_error_pulses", ecc_seen, ecc_expected);
      passed = 1'b1;
      $display("Testbench passed");
      $finish;
   end

   final begin
      if (!passed && !fail_shown) $display("Testbench failed");
   end

endmodule

// ==== files.f ====
logic/csi_rx_pkg.sv
logic/csi_rx_hdr_ecc.sv
logic/csi_rx_word_aligner.sv
logic/csi_rx_byte_counter.sv
logic/csi_rx_packet_handler.sv
logic/csi_rx_stream_buffer.sv
logic/csi_rx_top.sv
testbench/csi_rx_props.sv
testbench/csi_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the csi-2 receiver testbench with verilator, runs it and scans the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module csi_rx_tb \
   -f files.f -o csi_rx_sim \
   && ./obj_dir/csi_rx_sim > sim.log 2>&1
grep -qx "Testbench passed" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
